/* source/tsp_cfg.svh */
`ifndef TSP_CFG_SVH
`define TSP_CFG_SVH

// Tour size
`define CITY_NUM 8
`define CITY_LOG 3

// Replica array size
`define REPLICA_NUM 4

// Distance entry, unsigned
`define DIST_W 10

// Signed tour length change
`define DELTA_W 14

`endif

/* source/replica_pkg.sv */
`include "tsp_cfg.svh"

package replica_pkg;

    typedef logic [`CITY_LOG-1:0] city_t;

    // Element p holds the city at tour position p
    typedef city_t [`CITY_NUM-1:0] tour_t;

    typedef enum logic [1:0] {
        OPT_NOP = 2'd0,
        OPT_TWO = 2'd1,
        OPT_OR  = 2'd2
    } opt_op_t;

    typedef struct packed {
        opt_op_t              op;
        logic [`CITY_LOG-1:0] k;  // Tour positions, not city ids
        logic [`CITY_LOG-1:0] l;
    } opt_t;

    // Edges around positions k and l of the current tour
    typedef enum logic [2:0] {
        KM, KN, KP, LN, XA, XB, LK, KL
    } edge_sel_t;

    typedef enum logic [1:0] {
        D_ZERO = 2'd0,
        D_PLS  = 2'd1,
        D_MNS  = 2'd2,
        D_NOP  = 2'd3
    } dist_op_t;

    typedef struct packed {
        edge_sel_t sel;
        dist_op_t  op;
    } distance_command_t;

    typedef enum logic [1:0] {
        X_HOLD      = 2'd0,
        X_TAKE_PREV = 2'd1,
        X_TAKE_FOLW = 2'd2
    } xchg_dir_t;

    typedef logic signed [`DELTA_W-1:0] delta_t;

endpackage

/* source/distance_ram.sv */
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module distance_ram (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       we,
    input  logic [2*`CITY_LOG-1:0]     w_addr,
    input  logic [`DIST_W-1:0]         w_data,
    input  replica_pkg::city_t         r_a,
    input  replica_pkg::city_t         r_b,
    output logic [`DIST_W-1:0]         r_data
);

    logic [`DIST_W-1:0] mem [0:`CITY_NUM*`CITY_NUM-1];

    // Entry for pair a,b lives at a*8+b
    logic [2*`CITY_LOG-1:0] r_addr;

    assign r_addr = {r_a, r_b};

    always_ff @(posedge clk) begin
        if (we) begin
            mem[w_addr] <= w_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (reset) begin
            r_data <= '0;
        end else begin
            r_data <= mem[r_addr];
        end
    end

endmodule

/* source/delta_sequencer.sv */
`timescale 1ns/1ps

module delta_sequencer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  replica_pkg::opt_op_t           op,
    output replica_pkg::distance_command_t cmd,
    output logic                           done
);

    import replica_pkg::*;

    localparam logic [2:0] LAST_STEP = 3'd6;

    logic       busy;
    logic [2:0] step;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= busy && (step == LAST_STEP);
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                if (step == LAST_STEP) begin
                    busy <= 1'b0;
                end
                step <= step + 3'd1;
            end
        end
    end

    // Edge list per opcode, clear first
    always_comb begin
        cmd = '{sel: KN, op: D_NOP};
        if (busy) begin
            if (step == 3'd0) begin
                cmd = '{sel: KN, op: D_ZERO};
            end else if (op == OPT_TWO) begin
                case (step)
                    3'd1:    cmd = '{sel: KM, op: D_MNS};
                    3'd2:    cmd = '{sel: LN, op: D_MNS};
                    3'd3:    cmd = '{sel: XA, op: D_PLS};
                    3'd4:    cmd = '{sel: XB, op: D_PLS};
                    default: cmd = '{sel: KN, op: D_NOP};  // Padding
                endcase
            end else if (op == OPT_OR) begin
                case (step)
                    3'd1:    cmd = '{sel: KM, op: D_MNS};
                    3'd2:    cmd = '{sel: KN, op: D_MNS};
                    3'd3:    cmd = '{sel: LN, op: D_MNS};
                    3'd4:    cmd = '{sel: KP, op: D_PLS};
                    3'd5:    cmd = '{sel: LK, op: D_PLS};
                    3'd6:    cmd = '{sel: KL, op: D_PLS};
                    default: cmd = '{sel: KN, op: D_NOP};
                endcase
            end
        end
    end

endmodule

/* source/replica.sv */
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module replica (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    distance_write,
    input  logic [2*`CITY_LOG-1:0]  distance_w_addr,
    input  logic [`DIST_W-1:0]      distance_w_data,
    input  replica_pkg::opt_t       opt,
    input  logic                    start,
    input  replica_pkg::xchg_dir_t  xchg,
    input  logic                    shift_en,
    input  replica_pkg::tour_t      prev_tour,
    input  replica_pkg::tour_t      folw_tour,
    output replica_pkg::tour_t      tour,
    output replica_pkg::delta_t     delta,
    output logic                    delta_valid
);

    import replica_pkg::*;

    opt_t                 opt_l;
    distance_command_t    cmd;
    logic                 seq_done;
    logic                 done_d1;
    logic [`CITY_LOG-1:0] k_prev;
    logic [`CITY_LOG-1:0] k_next;
    logic [`CITY_LOG-1:0] l_next;
    city_t                r_a;
    city_t                r_b;
    logic [`DIST_W-1:0]   r_data;
    dist_op_t             op_d1;
    delta_t               acc;

    // Shift has priority, host never overlaps it with an exchange
    always_ff @(posedge clk) begin
        if (reset) begin
            tour <= '0;
        end else if (shift_en) begin
            tour <= prev_tour;
        end else begin
            case (xchg)
                X_TAKE_PREV: tour <= prev_tour;
                X_TAKE_FOLW: tour <= folw_tour;
                default:     tour <= tour;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opt_l <= '{op: OPT_NOP, k: '0, l: '0};
        end else if (start) begin
            opt_l <= opt;
        end
    end

    delta_sequencer u_seq (
        .clk   ( clk      ),
        .reset ( reset    ),
        .start ( start    ),
        .op    ( opt_l.op ),
        .cmd   ( cmd      ),
        .done  ( seq_done )
    );

    // Neighbour positions wrap mod 8
    assign k_prev = opt_l.k - 1'b1;
    assign k_next = opt_l.k + 1'b1;
    assign l_next = opt_l.l + 1'b1;

    always_comb begin
        case (cmd.sel)
            KM: begin
                r_a = tour[k_prev];
                r_b = tour[opt_l.k];
            end
            KN: begin
                r_a = tour[opt_l.k];
                r_b = tour[k_next];
            end
            KP: begin
                r_a = tour[k_prev];
                r_b = tour[k_next];
            end
            LN: begin
                r_a = tour[opt_l.l];
                r_b = tour[l_next];
            end
            XA: begin
                r_a = tour[k_prev];
                r_b = tour[opt_l.l];
            end
            LK: begin
                r_a = tour[opt_l.l];
                r_b = tour[opt_l.k];
            end
            default: begin  // XB and KL are the same edge
                r_a = tour[opt_l.k];
                r_b = tour[l_next];
            end
        endcase
    end

    distance_ram u_ram (
        .clk    ( clk             ),
        .reset  ( reset           ),
        .we     ( distance_write  ),
        .w_addr ( distance_w_addr ),
        .w_data ( distance_w_data ),
        .r_a    ( r_a             ),
        .r_b    ( r_b             ),
        .r_data ( r_data          )
    );

    // Op travels alongside the RAM read
    always_ff @(posedge clk) begin
        if (reset) begin
            op_d1   <= D_NOP;
            done_d1 <= 1'b0;
        end else begin
            op_d1   <= cmd.op;
            done_d1 <= seq_done;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else begin
            case (op_d1)
                D_ZERO:  acc <= '0;
                D_PLS:   acc <= acc + delta_t'(r_data);
                D_MNS:   acc <= acc - delta_t'(r_data);
                default: acc <= acc;
            endcase
        end
    end

    // Last edge lands in acc as done_d1 rises
    always_ff @(posedge clk) begin
        if (reset) begin
            delta       <= '0;
            delta_valid <= 1'b0;
        end else begin
            delta_valid <= done_d1;
            if (done_d1) begin
                delta <= acc;
            end
        end
    end

endmodule

/* source/replica_top.sv */
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module replica_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    distance_write,
    input  logic [2*`CITY_LOG-1:0]                  distance_w_addr,
    input  logic [`DIST_W-1:0]                      distance_w_data,
    input  logic                                    set_opt,
    input  replica_pkg::opt_t                       opt_in,
    input  logic                                    run_eval,
    input  logic                                    xchg_valid,
    input  logic [`REPLICA_NUM-2:0]                 xchg_mask,
    input  logic                                    tour_in_valid,
    input  replica_pkg::tour_t                      tour_in,
    output logic                                    tour_out_valid,
    output replica_pkg::tour_t                      tour_out,
    output logic                                    delta_valid,
    output replica_pkg::delta_t [`REPLICA_NUM-1:0]  delta_out
);

    import replica_pkg::*;

    localparam int IDX_W = $clog2(`REPLICA_NUM);

    opt_t [`REPLICA_NUM-1:0]  opt_bank;
    logic [IDX_W-1:0]         opt_idx;
    xchg_dir_t                xchg_dir [`REPLICA_NUM];
    logic                     shift_en;
    tour_t                    tour_in_d1;
    logic [`REPLICA_NUM-1:0]  replica_valid;

    // link[g+1] is replica g, ends are the input stage and zero
    tour_t link [`REPLICA_NUM+2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REPLICA_NUM; i++) begin
                opt_bank[i] <= '{op: OPT_NOP, k: '0, l: '0};
            end
            opt_idx <= '0;
        end else if (run_eval) begin
            opt_idx <= '0;  // Bank contents stay for the next run
        end else if (set_opt) begin
            opt_bank[opt_idx] <= opt_in;
            opt_idx           <= opt_idx + 1'b1;
        end
    end

    // One-cycle exchange pulse per replica
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REPLICA_NUM; i++) begin
                xchg_dir[i] <= X_HOLD;
            end
        end else begin
            for (int i = 0; i < `REPLICA_NUM; i++) begin
                xchg_dir[i] <= X_HOLD;
            end
            if (xchg_valid) begin
                for (int i = 0; i < `REPLICA_NUM-1; i++) begin
                    if (xchg_mask[i]) begin
                        xchg_dir[i]   <= X_TAKE_FOLW;
                        xchg_dir[i+1] <= X_TAKE_PREV;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            shift_en <= 1'b0;
        end else begin
            shift_en <= tour_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        tour_in_d1 <= tour_in;
    end

    assign link[0]              = tour_in_d1;
    assign link[`REPLICA_NUM+1] = '0;

    // Last replica's tour leaves while the chain shifts
    assign tour_out_valid = shift_en;
    assign tour_out       = link[`REPLICA_NUM];

    for (genvar g = 0; g < `REPLICA_NUM; g++) begin : g_replica
        replica u_replica (
            .clk             ( clk              ),
            .reset           ( reset            ),
            .distance_write  ( distance_write   ),
            .distance_w_addr ( distance_w_addr  ),
            .distance_w_data ( distance_w_data  ),
            .opt             ( opt_bank[g]      ),
            .start           ( run_eval         ),
            .xchg            ( xchg_dir[g]      ),
            .shift_en        ( shift_en         ),
            .prev_tour       ( link[g]          ),
            .folw_tour       ( link[g+2]        ),
            .tour            ( link[g+1]        ),
            .delta           ( delta_out[g]     ),
            .delta_valid     ( replica_valid[g] )
        );
    end

    assign delta_valid = replica_valid[0];  // All replicas finish together

endmodule

/* sim/replica_asserts.sv */
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module replica_asserts (
    input logic                    clk,
    input logic                    reset,
    input logic                    run_eval,
    input logic                    delta_valid,
    input logic                    xchg_valid,
    input logic [`REPLICA_NUM-2:0] xchg_mask,
    input logic                    tour_in_valid,
    input logic                    tour_out_valid
);

    // Recent run_eval samples with the newest in bit 0
    logic [8:0] run_hist;

    always_ff @(posedge clk) begin
        if (reset) begin
            run_hist <= '0;
        end else begin
            run_hist <= {run_hist[7:0], run_eval};
        end
    end

    a_delta_gap: assert property (@(posedge clk) disable iff (reset)
        $rose(delta_valid) |-> (run_hist == '0))
        else $error("delta_valid rose within 8 cycles of run_eval");

    a_mask_legal: assert property (@(posedge clk) disable iff (reset)
        xchg_valid |-> ((xchg_mask & (xchg_mask >> 1)) == '0))
        else $error("xchg_mask has adjacent bits set");

    a_out_follows: assert property (@(posedge clk) disable iff (reset)
        tour_in_valid |=> tour_out_valid)
        else $error("tour_out_valid missing one cycle after tour_in_valid");

    a_out_idle: assert property (@(posedge clk) disable iff (reset)
        !tour_in_valid |=> !tour_out_valid)
        else $error("tour_out_valid without tour_in_valid one cycle before");

endmodule

bind replica_top replica_asserts u_asserts (
    .clk            ( clk            ),
    .reset          ( reset          ),
    .run_eval       ( run_eval       ),
    .delta_valid    ( delta_valid    ),
    .xchg_valid     ( xchg_valid     ),
    .xchg_mask      ( xchg_mask      ),
    .tour_in_valid  ( tour_in_valid  ),
    .tour_out_valid ( tour_out_valid )
);

/* sim/tb_replica_top.sv */
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module tb_replica_top;

    import replica_pkg::*;

    localparam int CYCLE_LIMIT = 4000;
    localparam int ROUNDS      = 50;

    logic                             clk = 1'b0;
    logic                             reset;
    logic                             distance_write;
    logic [2*`CITY_LOG-1:0]           distance_w_addr;
    logic [`DIST_W-1:0]               distance_w_data;
    logic                             set_opt;
    opt_t                             opt_in;
    logic                             run_eval;
    logic                             xchg_valid;
    logic [`REPLICA_NUM-2:0]          xchg_mask;
    logic                             tour_in_valid;
    tour_t                            tour_in;
    logic                             tour_out_valid;
    tour_t                            tour_out;
    logic                             delta_valid;
    delta_t [`REPLICA_NUM-1:0]        delta_out;

    integer seed        = 32'h621;
    int     cycle_count = 0;

    // Reference model
    int    dist_m [`CITY_NUM*`CITY_NUM];
    tour_t tours_m [`REPLICA_NUM];  // Index 0 is the head of the chain
    opt_t  opts_m [`REPLICA_NUM];

    always #2 clk = ~clk;

    replica_top uut (
        .clk             ( clk             ),
        .reset           ( reset           ),
        .distance_write  ( distance_write  ),
        .distance_w_addr ( distance_w_addr ),
        .distance_w_data ( distance_w_data ),
        .set_opt         ( set_opt         ),
        .opt_in          ( opt_in          ),
        .run_eval        ( run_eval        ),
        .xchg_valid      ( xchg_valid      ),
        .xchg_mask       ( xchg_mask       ),
        .tour_in_valid   ( tour_in_valid   ),
        .tour_in         ( tour_in         ),
        .tour_out_valid  ( tour_out_valid  ),
        .tour_out        ( tour_out        ),
        .delta_valid     ( delta_valid     ),
        .delta_out       ( delta_out       )
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("TEST FAIL");
            $fatal(1, "Cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic tour_t random_tour();
        return (`CITY_NUM*`CITY_LOG)'($random(seed));
    endfunction

    // Drops the lower bit of every adjacent pair
    function automatic logic [`REPLICA_NUM-2:0] legal_mask();
        logic [`REPLICA_NUM-2:0] m;
        m = (`REPLICA_NUM-1)'($random(seed));
        return m & ~(m >> 1);
    endfunction

    function automatic int edge_len(city_t a, city_t b);
        return dist_m[{a, b}];
    endfunction

    function automatic int expected_delta(int g);
        tour_t       t;
        logic [2:0]  k;
        logic [2:0]  l;
        int          km;
        int          kn;
        int          kp;
        int          ln;
        int          xa;
        int          xb;
        int          lk;
        t  = tours_m[g];
        k  = opts_m[g].k;
        l  = opts_m[g].l;
        km = edge_len(t[k - 3'd1], t[k]);
        kn = edge_len(t[k], t[k + 3'd1]);
        kp = edge_len(t[k - 3'd1], t[k + 3'd1]);
        ln = edge_len(t[l], t[l + 3'd1]);
        xa = edge_len(t[k - 3'd1], t[l]);
        xb = edge_len(t[k], t[l + 3'd1]);
        lk = edge_len(t[l], t[k]);
        case (opts_m[g].op)
            OPT_TWO: return -km - ln + xa + xb;
            OPT_OR:  return -km - kn - ln + kp + lk + xb;  // KL is the XB edge
            default: return 0;
        endcase
    endfunction

    task automatic write_distance(input logic [2*`CITY_LOG-1:0] addr,
                                  input logic [`DIST_W-1:0] data);
        distance_write  = 1'b1;
        distance_w_addr = addr;
        distance_w_data = data;
        dist_m[addr]    = int'(data);
        next_cycle();
        distance_write  = 1'b0;
    endtask

    // Back to back shifts, the old tail shows one cycle after each input
    task automatic load_tours(input int n);
        tour_t t;
        for (int i = 0; i < n; i++) begin
            t             = random_tour();
            tour_in_valid = 1'b1;
            tour_in       = t;
            next_cycle();
            check_value("tour_out_valid", 32'(tour_out_valid), 32'd1);
            check_value("tour_out", 32'(tour_out), 32'(tours_m[`REPLICA_NUM-1]));
            for (int r = `REPLICA_NUM-1; r > 0; r--) begin
                tours_m[r] = tours_m[r-1];
            end
            tours_m[0] = t;
        end
        tour_in_valid = 1'b0;
        next_cycle();  // Last shift lands here
        check_value("tour_out_valid", 32'(tour_out_valid), 32'd0);
    endtask

    task automatic exchange_tours(input logic [`REPLICA_NUM-2:0] mask);
        tour_t tmp;
        xchg_valid = 1'b1;
        xchg_mask  = mask;
        next_cycle();
        xchg_valid = 1'b0;
        xchg_mask  = '0;
        next_cycle();
        for (int g = 0; g < `REPLICA_NUM-1; g++) begin
            if (mask[g]) begin
                tmp          = tours_m[g];
                tours_m[g]   = tours_m[g+1];
                tours_m[g+1] = tmp;
            end
        end
    endtask

    task automatic set_moves();
        opt_t       o;
        logic [1:0] pick;
        for (int g = 0; g < `REPLICA_NUM; g++) begin
            pick = 2'($random(seed));
            if (pick == 2'd0) begin
                o.op = OPT_NOP;
            end else if (pick[0]) begin
                o.op = OPT_TWO;
            end else begin
                o.op = OPT_OR;
            end
            o.k = city_t'($random(seed));
            // l stays clear of k and both its neighbours
            do begin
                o.l = city_t'($random(seed));
            end while (o.l == o.k || o.l == o.k - 3'd1 || o.l == o.k + 3'd1);
            opts_m[g] = o;
            set_opt   = 1'b1;
            opt_in    = o;
            next_cycle();
        end
        set_opt = 1'b0;
    endtask

    task automatic run_evaluation();
        int lat;
        run_eval = 1'b1;
        next_cycle();
        run_eval = 1'b0;
        lat      = 0;
        do begin
            next_cycle();
            lat++;
        end while (!delta_valid);
        check_value("delta_valid latency", 32'(lat), 32'd9);
        for (int g = 0; g < `REPLICA_NUM; g++) begin
            check_value($sformatf("delta_out[%0d]", g), 32'(delta_out[g]),
                        32'(expected_delta(g)));
        end
        next_cycle();
        check_value("delta_valid", 32'(delta_valid), 32'd0);  // Single pulse
    endtask

    initial begin
        reset           = 1'b1;
        distance_write  = 1'b0;
        distance_w_addr = '0;
        distance_w_data = '0;
        set_opt         = 1'b0;
        opt_in          = '0;
        run_eval        = 1'b0;
        xchg_valid      = 1'b0;
        xchg_mask       = '0;
        tour_in_valid   = 1'b0;
        tour_in         = '0;
        for (int i = 0; i < `REPLICA_NUM; i++) begin
            tours_m[i] = '0;
            opts_m[i]  = '{op: OPT_NOP, k: '0, l: '0};
        end
        for (int a = 0; a < `CITY_NUM*`CITY_NUM; a++) begin
            dist_m[a] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Empty chain first, then the first batch comes back in order
        load_tours(`REPLICA_NUM);
        load_tours(`REPLICA_NUM);

        for (int a = 0; a < `CITY_NUM*`CITY_NUM; a++) begin
            write_distance(6'(a), 10'($random(seed)));
        end
        set_moves();
        run_evaluation();

        repeat (6) exchange_tours(legal_mask());
        load_tours(`REPLICA_NUM);

        for (int r = 0; r < ROUNDS; r++) begin
            repeat (8) write_distance(6'($random(seed)), 10'($random(seed)));
            if (r % 3 == 0) begin
                exchange_tours(legal_mask());
            end
            load_tours(`REPLICA_NUM);
            set_moves();
            run_evaluation();
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/replica_pkg.sv
source/distance_ram.sv
source/delta_sequencer.sv
source/replica.sv
source/replica_top.sv
sim/replica_asserts.sv
sim/tb_replica_top.sv

/* Makefile */
TOP = tb_replica_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
